// File: hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // major opcodes
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // store and branch share the split immediate layout
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
    u_fmt_t u;
  } inst_u;

endpackage

`default_nettype wire

// File: hw/core_pkg.sv
`default_nettype none

package core_pkg;

  typedef enum logic [2:0] {
    ADD    = 3'd0,
    SUB    = 3'd1,
    AND    = 3'd2,
    OR     = 3'd3,
    XOR    = 3'd4,
    SLT    = 3'd5,
    PASS_B = 3'd6
  } alu_op_e;

  // where the pc goes after commit
  typedef enum logic [1:0] {
    SEQ    = 2'd0,
    BRANCH = 2'd1,
    JUMP   = 2'd2
  } pc_sel_e;

endpackage

`default_nettype wire

// File: hw/fetch_icache.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_icache #(
  parameter int ADDR_W       = 32,
  parameter int DATA_W       = 32,
  parameter int ICACHE_LINES = 256
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              fetch_ready_i,
  input  logic              redirect_valid_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,
  input  logic              ifu_rvalid_i,
  input  logic [DATA_W-1:0] ifu_rdata_i,
  output logic              fetch_valid_o,
  output logic [DATA_W-1:0] inst_o,
  output logic [ADDR_W-1:0] pc_o,
  output logic              ifu_arvalid_o,
  output logic [ADDR_W-1:0] ifu_araddr_o
);

  localparam int IDX_W = $clog2(ICACHE_LINES);
  localparam int TAG_W = ADDR_W - IDX_W - 2;

  logic [ADDR_W-1:0]       pc_q;
  logic                    lookup_q;
  logic                    pend_q;
  logic                    valid_q;
  logic [DATA_W-1:0]       inst_q;
  logic [DATA_W-1:0]       data_mem [ICACHE_LINES];
  logic [TAG_W-1:0]        tag_mem [ICACHE_LINES];
  logic [ICACHE_LINES-1:0] line_valid;

  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;
  logic             hit;
  logic             refill;

  assign idx    = pc_q[IDX_W+1:2];
  assign tag    = pc_q[ADDR_W-1:IDX_W+2];
  assign hit    = line_valid[idx] && (tag_mem[idx] == tag);
  assign refill = pend_q && ifu_rvalid_i;

  // refill word goes straight through in the rvalid cycle
  assign fetch_valid_o = valid_q || refill;
  assign inst_o        = refill ? ifu_rdata_i : inst_q;
  assign pc_o          = pc_q;
  assign ifu_arvalid_o = pend_q;
  assign ifu_araddr_o  = pc_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q       <= '0;
      lookup_q   <= 1'b1;
      pend_q     <= 1'b0;
      valid_q    <= 1'b0;
      line_valid <= '0;
    end
    else
    begin
      lookup_q <= 1'b0;
      if (redirect_valid_i)
      begin
        pc_q     <= redirect_pc_i;
        lookup_q <= 1'b1;
      end
      if (lookup_q)
      begin
        if (hit)
          valid_q <= 1'b1;
        else
          pend_q <= 1'b1;
      end
      if (refill)
      begin
        pend_q          <= 1'b0;
        line_valid[idx] <= 1'b1;
        // decode busy, keep the word
        if (!fetch_ready_i)
          valid_q <= 1'b1;
      end
      if (valid_q && fetch_ready_i)
        valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (lookup_q)
      inst_q <= data_mem[idx];
    if (refill)
    begin
      data_mem[idx] <= ifu_rdata_i;
      tag_mem[idx]  <= tag;
      inst_q        <= ifu_rdata_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file #(
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [4:0]        rs1_i,
  input  logic [4:0]        rs2_i,
  input  logic              we_i,
  input  logic [4:0]        rd_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata1_o,
  output logic [DATA_W-1:0] rdata2_o
);

  logic [DATA_W-1:0] regs [32];

  assign rdata1_o = regs[rs1_i];
  assign rdata2_o = regs[rs2_i];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int n = 0; n < 32; n++)
        regs[n] <= '0;
    end
    // x0 never written, stays zero from reset
    else if (we_i && (rd_i != 5'd0))
      regs[rd_i] <= wdata_i;
  end

endmodule

`default_nettype wire

// File: hw/decode.sv
`timescale 1ns/100ps
`default_nettype none

module decode #(
  parameter int DATA_W = 32
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                valid_i,
  input  logic [DATA_W-1:0]   inst_i,
  input  logic [DATA_W-1:0]   pc_i,
  input  logic                ready_i,
  input  logic [DATA_W-1:0]   rdata1_i,
  input  logic [DATA_W-1:0]   rdata2_i,
  output logic                ready_o,
  output logic                valid_o,
  output logic [4:0]          rs1_o,
  output logic [4:0]          rs2_o,
  output logic [DATA_W-1:0]   op_a_o,
  output logic [DATA_W-1:0]   op_b_o,
  output logic [DATA_W-1:0]   imm_o,
  output logic [DATA_W-1:0]   pc_o,
  output core_pkg::alu_op_e   alu_op_o,
  output core_pkg::pc_sel_e   pc_sel_o,
  output logic [4:0]          rd_o,
  output logic                we_o,
  output logic                is_branch_ne_o
);

  isa_pkg::inst_u    inst;
  logic [DATA_W-1:0] imm_d;
  core_pkg::alu_op_e alu_d;
  core_pkg::pc_sel_e sel_d;
  logic              use_pc_d;
  logic              use_imm_d;
  logic              we_d;
  logic              accept;

  function automatic core_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic sub);
    case (f3)
      isa_pkg::F3_ADD: alu_sel = sub ? core_pkg::SUB : core_pkg::ADD;
      isa_pkg::F3_SLT: alu_sel = core_pkg::SLT;
      isa_pkg::F3_XOR: alu_sel = core_pkg::XOR;
      isa_pkg::F3_OR:  alu_sel = core_pkg::OR;
      isa_pkg::F3_AND: alu_sel = core_pkg::AND;
      default:         alu_sel = core_pkg::ADD;
    endcase
  endfunction

  assign inst    = inst_i;
  assign rs1_o   = inst.r.rs1;
  assign rs2_o   = inst.r.rs2;
  assign ready_o = !valid_o;
  assign accept  = valid_i && ready_o;

  always_comb
  begin
    imm_d     = '0;
    alu_d     = core_pkg::ADD;
    sel_d     = core_pkg::SEQ;
    use_pc_d  = 1'b0;
    use_imm_d = 1'b0;
    we_d      = 1'b0;
    case (inst.r.opcode)
      isa_pkg::OP_REG:
      begin
        alu_d = alu_sel(inst.r.funct3, inst.r.funct7[5]);
        we_d  = 1'b1;
      end
      isa_pkg::OP_IMM:
      begin
        imm_d     = DATA_W'($signed(inst.i.imm));
        alu_d     = alu_sel(inst.i.funct3, 1'b0);
        use_imm_d = 1'b1;
        we_d      = 1'b1;
      end
      isa_pkg::OP_LUI:
      begin
        imm_d     = DATA_W'({inst.u.imm, 12'b0});
        alu_d     = core_pkg::PASS_B;
        use_imm_d = 1'b1;
        we_d      = 1'b1;
      end
      isa_pkg::OP_AUIPC:
      begin
        imm_d     = DATA_W'({inst.u.imm, 12'b0});
        use_pc_d  = 1'b1;
        use_imm_d = 1'b1;
        we_d      = 1'b1;
      end
      isa_pkg::OP_BRANCH:
      begin
        imm_d = DATA_W'($signed({inst.b.imm12, inst.b.imm11, inst.b.imm10_5,
                                 inst.b.imm4_1, 1'b0}));
        // other compares are not supported, they fall through as nops
        if (inst.b.funct3 == isa_pkg::F3_BEQ || inst.b.funct3 == isa_pkg::F3_BNE)
          sel_d = core_pkg::BRANCH;
      end
      isa_pkg::OP_JAL:
      begin
        // jal immediate rebuilt from the u-format field
        imm_d    = DATA_W'($signed({inst.u.imm[19], inst.u.imm[7:0], inst.u.imm[8],
                                    inst.u.imm[18:9], 1'b0}));
        sel_d    = core_pkg::JUMP;
        use_pc_d = 1'b1;
        we_d     = 1'b1;
      end
      default:
      begin
        we_d = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      valid_o <= 1'b0;
    else if (accept)
      valid_o <= 1'b1;
    else if (ready_i)
      valid_o <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      op_a_o         <= use_pc_d ? pc_i : rdata1_i;
      op_b_o         <= use_imm_d ? imm_d : rdata2_i;
      imm_o          <= imm_d;
      pc_o           <= pc_i;
      alu_op_o       <= alu_d;
      pc_sel_o       <= sel_d;
      rd_o           <= inst.r.rd;
      we_o           <= we_d;
      is_branch_ne_o <= (inst.b.funct3 == isa_pkg::F3_BNE);
    end
  end

endmodule

`default_nettype wire

// File: hw/execute.sv
`timescale 1ns/100ps
`default_nettype none

module execute #(
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              valid_i,
  input  logic              ready_i,
  input  logic [DATA_W-1:0] op_a_i,
  input  logic [DATA_W-1:0] op_b_i,
  input  logic [DATA_W-1:0] rs2val_i,
  input  logic [DATA_W-1:0] imm_i,
  input  logic [DATA_W-1:0] pc_i,
  input  core_pkg::alu_op_e alu_op_i,
  input  core_pkg::pc_sel_e pc_sel_i,
  input  logic              is_branch_ne_i,
  input  logic [4:0]        rd_i,
  input  logic              we_i,
  output logic              ready_o,
  output logic              valid_o,
  output logic [DATA_W-1:0] result_o,
  output logic [DATA_W-1:0] target_o,
  output logic              taken_o,
  output core_pkg::pc_sel_e pc_sel_o,
  output logic [4:0]        rd_o,
  output logic              we_o,
  output logic [DATA_W-1:0] pc_o
);

  logic [DATA_W-1:0] alu_y;
  logic              eq;
  logic              taken_d;
  logic              accept;

  assign ready_o = !valid_o;
  assign accept  = valid_i && ready_o;
  assign eq      = (op_a_i == rs2val_i);

  always_comb
  begin
    case (alu_op_i)
      core_pkg::ADD:    alu_y = op_a_i + op_b_i;
      core_pkg::SUB:    alu_y = op_a_i - op_b_i;
      core_pkg::AND:    alu_y = op_a_i & op_b_i;
      core_pkg::OR:     alu_y = op_a_i | op_b_i;
      core_pkg::XOR:    alu_y = op_a_i ^ op_b_i;
      core_pkg::SLT:    alu_y = DATA_W'($signed(op_a_i) < $signed(op_b_i));
      core_pkg::PASS_B: alu_y = op_b_i;
      default:          alu_y = op_a_i + op_b_i;
    endcase
  end

  always_comb
  begin
    case (pc_sel_i)
      core_pkg::BRANCH: taken_d = eq ^ is_branch_ne_i;
      core_pkg::JUMP:   taken_d = 1'b1;
      default:          taken_d = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      valid_o <= 1'b0;
    else if (accept)
      valid_o <= 1'b1;
    else if (ready_i)
      valid_o <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      // link value for jal
      result_o <= (pc_sel_i == core_pkg::JUMP) ? pc_i + DATA_W'(4) : alu_y;
      target_o <= pc_i + imm_i;
      taken_o  <= taken_d;
      pc_sel_o <= pc_sel_i;
      rd_o     <= rd_i;
      we_o     <= we_i;
      pc_o     <= pc_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/result.sv
`timescale 1ns/100ps
`default_nettype none

module result #(
  parameter int ADDR_W = 32
) (
  input  logic              valid_i,
  input  logic [ADDR_W-1:0] result_i,
  input  logic [ADDR_W-1:0] target_i,
  input  logic              taken_i,
  input  core_pkg::pc_sel_e pc_sel_i,
  input  logic [4:0]        rd_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] pc_i,
  output logic              ready_o,
  output logic              rf_we_o,
  output logic [4:0]        rf_rd_o,
  output logic [ADDR_W-1:0] rf_wdata_o,
  output logic              redirect_valid_o,
  output logic [ADDR_W-1:0] redirect_pc_o,
  output logic              commit_valid_o,
  output logic [ADDR_W-1:0] commit_pc_o,
  output logic [4:0]        commit_rd_o,
  output logic              commit_we_o,
  output logic [ADDR_W-1:0] commit_data_o
);

  logic redirect_taken;

  // nothing is held here, commit happens on accept
  assign ready_o = 1'b1;

  assign redirect_taken = taken_i && (pc_sel_i != core_pkg::SEQ);

  assign rf_we_o    = valid_i && we_i;
  assign rf_rd_o    = rd_i;
  assign rf_wdata_o = result_i;

  assign redirect_valid_o = valid_i;
  assign redirect_pc_o    = redirect_taken ? target_i : pc_i + ADDR_W'(4);

  assign commit_valid_o = valid_i;
  assign commit_pc_o    = pc_i;
  assign commit_rd_o    = rd_i;
  assign commit_we_o    = we_i;
  assign commit_data_o  = result_i;

endmodule

`default_nettype wire

// File: hw/core_top.sv
`timescale 1ns/100ps
`default_nettype none

module core_top #(
  parameter int ADDR_W       = 32,
  parameter int DATA_W       = 32,
  parameter int ICACHE_LINES = 256
) (
  input  logic              clk,
  input  logic              rst,
  output logic              ifu_arvalid_o,
  output logic [ADDR_W-1:0] ifu_araddr_o,
  input  logic              ifu_rvalid_i,
  input  logic [DATA_W-1:0] ifu_rdata_i,
  output logic              commit_valid_o,
  output logic [ADDR_W-1:0] commit_pc_o,
  output logic [4:0]        commit_rd_o,
  output logic              commit_we_o,
  output logic [DATA_W-1:0] commit_data_o
);

  // fetch to decode
  logic              fetch_valid;
  logic              fetch_ready;
  logic [DATA_W-1:0] inst;
  logic [ADDR_W-1:0] pc;

  // decode to execute
  logic              dec_valid;
  logic              dec_ready;
  logic [4:0]        dec_rs1;
  logic [4:0]        dec_rs2;
  logic [DATA_W-1:0] dec_op_a;
  logic [DATA_W-1:0] dec_op_b;
  logic [DATA_W-1:0] dec_imm;
  logic [DATA_W-1:0] dec_pc;
  core_pkg::alu_op_e dec_alu_op;
  core_pkg::pc_sel_e dec_pc_sel;
  logic [4:0]        dec_rd;
  logic              dec_we;
  logic              dec_bne;

  // execute to result
  logic              exe_valid;
  logic              exe_ready;
  logic [DATA_W-1:0] exe_result;
  logic [DATA_W-1:0] exe_target;
  logic              exe_taken;
  core_pkg::pc_sel_e exe_pc_sel;
  logic [4:0]        exe_rd;
  logic              exe_we;
  logic [DATA_W-1:0] exe_pc;

  logic [DATA_W-1:0] rdata1;
  logic [DATA_W-1:0] rdata2;
  logic              rf_we;
  logic [4:0]        rf_rd;
  logic [DATA_W-1:0] rf_wdata;
  logic              redirect_valid;
  logic [ADDR_W-1:0] redirect_pc;

  fetch_icache #(
    .ADDR_W      (ADDR_W),
    .DATA_W      (DATA_W),
    .ICACHE_LINES(ICACHE_LINES)
  ) u_fetch_icache (
    .clk             (clk),
    .rst             (rst),
    .fetch_ready_i   (fetch_ready),
    .redirect_valid_i(redirect_valid),
    .redirect_pc_i   (redirect_pc),
    .ifu_rvalid_i    (ifu_rvalid_i),
    .ifu_rdata_i     (ifu_rdata_i),
    .fetch_valid_o   (fetch_valid),
    .inst_o          (inst),
    .pc_o            (pc),
    .ifu_arvalid_o   (ifu_arvalid_o),
    .ifu_araddr_o    (ifu_araddr_o)
  );

  reg_file #(
    .DATA_W(DATA_W)
  ) u_reg_file (
    .clk     (clk),
    .rst     (rst),
    .rs1_i   (dec_rs1),
    .rs2_i   (dec_rs2),
    .we_i    (rf_we),
    .rd_i    (rf_rd),
    .wdata_i (rf_wdata),
    .rdata1_o(rdata1),
    .rdata2_o(rdata2)
  );

  decode #(
    .DATA_W(DATA_W)
  ) u_decode (
    .clk           (clk),
    .rst           (rst),
    .valid_i       (fetch_valid),
    .inst_i        (inst),
    .pc_i          (pc),
    .ready_i       (dec_ready),
    .rdata1_i      (rdata1),
    .rdata2_i      (rdata2),
    .ready_o       (fetch_ready),
    .valid_o       (dec_valid),
    .rs1_o         (dec_rs1),
    .rs2_o         (dec_rs2),
    .op_a_o        (dec_op_a),
    .op_b_o        (dec_op_b),
    .imm_o         (dec_imm),
    .pc_o          (dec_pc),
    .alu_op_o      (dec_alu_op),
    .pc_sel_o      (dec_pc_sel),
    .rd_o          (dec_rd),
    .we_o          (dec_we),
    .is_branch_ne_o(dec_bne)
  );

  // operand b carries rs2 for branches
  execute #(
    .DATA_W(DATA_W)
  ) u_execute (
    .clk           (clk),
    .rst           (rst),
    .valid_i       (dec_valid),
    .ready_i       (exe_ready),
    .op_a_i        (dec_op_a),
    .op_b_i        (dec_op_b),
    .rs2val_i      (dec_op_b),
    .imm_i         (dec_imm),
    .pc_i          (dec_pc),
    .alu_op_i      (dec_alu_op),
    .pc_sel_i      (dec_pc_sel),
    .is_branch_ne_i(dec_bne),
    .rd_i          (dec_rd),
    .we_i          (dec_we),
    .ready_o       (dec_ready),
    .valid_o       (exe_valid),
    .result_o      (exe_result),
    .target_o      (exe_target),
    .taken_o       (exe_taken),
    .pc_sel_o      (exe_pc_sel),
    .rd_o          (exe_rd),
    .we_o          (exe_we),
    .pc_o          (exe_pc)
  );

  result #(
    .ADDR_W(ADDR_W)
  ) u_result (
    .valid_i         (exe_valid),
    .result_i        (exe_result),
    .target_i        (exe_target),
    .taken_i         (exe_taken),
    .pc_sel_i        (exe_pc_sel),
    .rd_i            (exe_rd),
    .we_i            (exe_we),
    .pc_i            (exe_pc),
    .ready_o         (exe_ready),
    .rf_we_o         (rf_we),
    .rf_rd_o         (rf_rd),
    .rf_wdata_o      (rf_wdata),
    .redirect_valid_o(redirect_valid),
    .redirect_pc_o   (redirect_pc),
    .commit_valid_o  (commit_valid_o),
    .commit_pc_o     (commit_pc_o),
    .commit_rd_o     (commit_rd_o),
    .commit_we_o     (commit_we_o),
    .commit_data_o   (commit_data_o)
  );

endmodule

`default_nettype wire

// File: tests/core_properties.sv
`timescale 1ns/100ps
`default_nettype none

module core_properties (
  input  logic        clk,
  input  logic        rst,
  input  logic        ifu_arvalid_i,
  input  logic [31:0] ifu_araddr_i,
  input  logic        ifu_rvalid_i,
  input  logic [31:0] ifu_rdata_i,
  input  logic        commit_valid_i,
  input  logic [31:0] commit_pc_i,
  input  logic [4:0]  commit_rd_i,
  input  logic        commit_we_i,
  input  logic [31:0] commit_data_i
);

  logic [31:0]    shadow_regs [32];
  logic [31:0]    seen_word [256];
  logic [255:0]   seen;
  logic [31:0]    exp_pc;
  logic [31:0]    branch_next;
  logic           after_branch;
  logic [31:0]    raw;
  isa_pkg::inst_u w;
  logic [31:0]    rs1v;
  logic [31:0]    rs2v;
  logic [31:0]    imm_i;
  logic [31:0]    imm_u;
  logic [31:0]    imm_b;
  logic [31:0]    imm_j;
  logic [31:0]    exp_data;
  logic [31:0]    exp_next;
  logic           exp_we;
  logic           br_taken;
  int unsigned    fail_count = 0;

  // reference model of the instruction at the expected pc
  always_comb
  begin
    raw      = seen_word[exp_pc[9:2]];
    w        = raw;
    rs1v     = shadow_regs[w.r.rs1];
    rs2v     = shadow_regs[w.r.rs2];
    imm_i    = {{20{raw[31]}}, raw[31:20]};
    imm_u    = {raw[31:12], 12'b0};
    imm_b    = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
    imm_j    = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
    exp_data = '0;
    exp_we   = 1'b0;
    exp_next = exp_pc + 32'd4;
    br_taken = 1'b0;
    case (w.r.opcode)
      isa_pkg::OP_REG,
      isa_pkg::OP_IMM:
      begin
        exp_we = 1'b1;
        if (w.r.opcode == isa_pkg::OP_IMM)
          rs2v = imm_i;
        case (w.r.funct3)
          isa_pkg::F3_ADD:
            exp_data = (w.r.opcode == isa_pkg::OP_REG && raw[30]) ? rs1v - rs2v : rs1v + rs2v;
          isa_pkg::F3_SLT: exp_data = {31'b0, $signed(rs1v) < $signed(rs2v)};
          isa_pkg::F3_XOR: exp_data = rs1v ^ rs2v;
          isa_pkg::F3_OR:  exp_data = rs1v | rs2v;
          isa_pkg::F3_AND: exp_data = rs1v & rs2v;
          default:         exp_data = '0;
        endcase
      end
      isa_pkg::OP_LUI:
      begin
        exp_we   = 1'b1;
        exp_data = imm_u;
      end
      isa_pkg::OP_AUIPC:
      begin
        exp_we   = 1'b1;
        exp_data = exp_pc + imm_u;
      end
      isa_pkg::OP_BRANCH:
      begin
        br_taken = (w.b.funct3 == isa_pkg::F3_BEQ) ? (rs1v == rs2v) : (rs1v != rs2v);
        if (br_taken)
          exp_next = exp_pc + imm_b;
      end
      isa_pkg::OP_JAL:
      begin
        exp_we   = 1'b1;
        exp_data = exp_pc + 32'd4;
        exp_next = exp_pc + imm_j;
      end
      default:
      begin
        exp_we = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      exp_pc       <= '0;
      seen         <= '0;
      after_branch <= 1'b0;
      branch_next  <= '0;
      for (int n = 0; n < 32; n++)
        shadow_regs[n] <= '0;
    end
    else
    begin
      if (ifu_arvalid_i && ifu_rvalid_i)
      begin
        seen[ifu_araddr_i[9:2]]      <= 1'b1;
        seen_word[ifu_araddr_i[9:2]] <= ifu_rdata_i;
      end
      if (commit_valid_i)
      begin
        exp_pc       <= exp_next;
        after_branch <= (w.r.opcode == isa_pkg::OP_BRANCH);
        branch_next  <= commit_pc_i + (br_taken ? imm_b : 32'd4);
        if (exp_we && w.r.rd != 5'd0)
          shadow_regs[w.r.rd] <= exp_data;
      end
    end
  end

  commit_pc_check: assert property (@(posedge clk) disable iff (rst)
    commit_valid_i |-> commit_pc_i == exp_pc)
  else
  begin
    fail_count++;
    $error("[FAIL] %0t commit_pc_o exp %h got %h", $time, exp_pc, commit_pc_i);
  end

  commit_data_check: assert property (@(posedge clk) disable iff (rst)
    commit_valid_i && exp_we |-> commit_data_i == exp_data)
  else
  begin
    fail_count++;
    $error("[FAIL] %0t commit_data_o exp %h got %h", $time, exp_data, commit_data_i);
  end

  commit_we_check: assert property (@(posedge clk) disable iff (rst)
    commit_valid_i |-> commit_we_i == exp_we)
  else
  begin
    fail_count++;
    $error("[FAIL] %0t commit_we_o exp %b got %b", $time, exp_we, commit_we_i);
  end

  commit_rd_check: assert property (@(posedge clk) disable iff (rst)
    commit_valid_i && exp_we |-> commit_rd_i == w.r.rd)
  else
  begin
    fail_count++;
    $error("[FAIL] %0t commit_rd_o exp %0d got %0d", $time, w.r.rd, commit_rd_i);
  end

  branch_next_check: assert property (@(posedge clk) disable iff (rst)
    commit_valid_i && after_branch |-> commit_pc_i == branch_next)
  else
  begin
    fail_count++;
    $error("[FAIL] %0t commit_pc_o exp %h got %h", $time, branch_next, commit_pc_i);
  end

  // slti from x0 must see zero even after x0 was a destination
  x0_read_check: assert property (@(posedge clk) disable iff (rst)
    commit_valid_i && w.r.opcode == isa_pkg::OP_IMM && w.i.rs1 == 5'd0
      && w.i.funct3 == isa_pkg::F3_SLT
      |-> commit_data_i == {31'b0, $signed(imm_i) > 0})
  else
  begin
    fail_count++;
    $error("[FAIL] %0t commit_data_o exp %h got %h", $time,
           {31'b0, $signed(imm_i) > 0}, commit_data_i);
  end

  araddr_stable_check: assert property (@(posedge clk) disable iff (rst)
    $past(ifu_arvalid_i && !ifu_rvalid_i)
      |-> ifu_arvalid_i && ifu_araddr_i == $past(ifu_araddr_i))
  else
  begin
    fail_count++;
    $error("[FAIL] %0t ifu_araddr_o exp %h got %h", $time, $past(ifu_araddr_i), ifu_araddr_i);
  end

  reset_idle_check: assert property (@(posedge clk)
    $past(rst) && !rst |-> !ifu_arvalid_i)
  else
  begin
    fail_count++;
    $error("[FAIL] %0t ifu_arvalid_o exp 0 got %b", $time, ifu_arvalid_i);
  end

  commit_idle_check: assert property (@(posedge clk)
    $past(rst) && !rst |-> !commit_valid_i)
  else
  begin
    fail_count++;
    $error("[FAIL] %0t commit_valid_o exp 0 got %b", $time, commit_valid_i);
  end

  cache_hit_check: assert property (@(posedge clk) disable iff (rst)
    ifu_arvalid_i |-> !seen[ifu_araddr_i[9:2]])
  else
  begin
    fail_count++;
    $error("bus request for cached pc %h at %0t", ifu_araddr_i, $time);
  end

endmodule

bind core_top core_properties u_props (
  .clk           (clk),
  .rst           (rst),
  .ifu_arvalid_i (ifu_arvalid_o),
  .ifu_araddr_i  (ifu_araddr_o),
  .ifu_rvalid_i  (ifu_rvalid_i),
  .ifu_rdata_i   (ifu_rdata_i),
  .commit_valid_i(commit_valid_o),
  .commit_pc_i   (commit_pc_o),
  .commit_rd_i   (commit_rd_o),
  .commit_we_i   (commit_we_o),
  .commit_data_i (commit_data_o)
);

`default_nettype wire

// File: tests/core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module core_tb;

  localparam int MEM_WORDS   = 256;
  localparam int RST_CYCLES  = 10;
  localparam int END_COMMITS = 50;
  localparam int MAX_CYCLES  = 60 * 8 + RST_CYCLES;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        ifu_arvalid;
  logic [31:0] ifu_araddr;
  logic        ifu_rvalid = 1'b0;
  logic [31:0] ifu_rdata = '0;
  logic        commit_valid;
  logic [31:0] commit_pc;
  logic [4:0]  commit_rd;
  logic        commit_we;
  logic [31:0] commit_data;

  logic [31:0] imem [MEM_WORDS];
  logic [31:0] rng = 32'd32065;
  logic        busy = 1'b0;
  logic [2:0]  wait_cnt = 3'd0;
  logic [31:0] req_addr = '0;
  int          commits = 0;
  int          cycles = 0;
  int          tb_errors;

  core_top u_core_top (
    .clk           (clk),
    .rst           (rst),
    .ifu_arvalid_o (ifu_arvalid),
    .ifu_araddr_o  (ifu_araddr),
    .ifu_rvalid_i  (ifu_rvalid),
    .ifu_rdata_i   (ifu_rdata),
    .commit_valid_o(commit_valid),
    .commit_pc_o   (commit_pc),
    .commit_rd_o   (commit_rd),
    .commit_we_o   (commit_we),
    .commit_data_o (commit_data)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, isa_pkg::OP_REG};
  endfunction

  function automatic logic [31:0] imm_op(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, isa_pkg::OP_IMM};
  endfunction

  function automatic logic [31:0] upper_op(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] branch_op(input logic [12:0] off, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], isa_pkg::OP_BRANCH};
  endfunction

  function automatic logic [31:0] jump_op(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, isa_pkg::OP_JAL};
  endfunction

  task automatic load_program();
    for (int n = 0; n < MEM_WORDS; n++)
      imem[n] = 32'hA5A50000 ^ (32'(n) * 32'h00010001);
    imem[0]  = imm_op(12'd2, 5'd0, isa_pkg::F3_ADD, 5'd1);
    // loop body starts at 4
    imem[1]  = upper_op(20'h12345, 5'd2, isa_pkg::OP_LUI);
    imem[2]  = upper_op(20'h00001, 5'd3, isa_pkg::OP_AUIPC);
    imem[3]  = reg_op(7'h00, 5'd2, 5'd5, isa_pkg::F3_ADD, 5'd5);
    imem[4]  = reg_op(7'h20, 5'd3, 5'd5, isa_pkg::F3_ADD, 5'd6);
    imem[5]  = reg_op(7'h00, 5'd2, 5'd6, isa_pkg::F3_XOR, 5'd7);
    imem[6]  = reg_op(7'h00, 5'd1, 5'd7, isa_pkg::F3_OR, 5'd8);
    imem[7]  = reg_op(7'h00, 5'd6, 5'd8, isa_pkg::F3_AND, 5'd9);
    imem[8]  = reg_op(7'h00, 5'd5, 5'd6, isa_pkg::F3_SLT, 5'd10);
    imem[9]  = imm_op(12'd7, 5'd5, isa_pkg::F3_ADD, 5'd0);
    imem[10] = imm_op(12'd1, 5'd0, isa_pkg::F3_SLT, 5'd11);
    imem[11] = imm_op(12'h070, 5'd11, isa_pkg::F3_OR, 5'd12);
    imem[12] = imm_op(12'h03c, 5'd12, isa_pkg::F3_AND, 5'd13);
    imem[13] = imm_op(-12'sd1, 5'd13, isa_pkg::F3_XOR, 5'd14);
    imem[14] = branch_op(13'd8, 5'd0, 5'd11, isa_pkg::F3_BEQ);
    imem[15] = branch_op(13'd8, 5'd5, 5'd5, isa_pkg::F3_BEQ);
    // skipped by the taken beq
    imem[16] = imm_op(12'd99, 5'd0, isa_pkg::F3_ADD, 5'd15);
    imem[17] = branch_op(13'd8, 5'd0, 5'd0, isa_pkg::F3_BNE);
    imem[18] = imm_op(-12'sd1, 5'd1, isa_pkg::F3_ADD, 5'd1);
    imem[19] = branch_op(-13'sd72, 5'd0, 5'd1, isa_pkg::F3_BNE);
    imem[20] = jump_op(21'd0, 5'd16);
  endtask

  // memory answers each request after 1 to 4 cycles
  always @(posedge clk)
  begin
    if (rst)
    begin
      busy       <= 1'b0;
      ifu_rvalid <= 1'b0;
    end
    else
    begin
      ifu_rvalid <= 1'b0;
      if (busy)
      begin
        if (wait_cnt == 3'd1)
        begin
          ifu_rvalid <= 1'b1;
          ifu_rdata  <= imem[req_addr[9:2]];
          busy       <= 1'b0;
        end
        else
          wait_cnt <= wait_cnt - 3'd1;
      end
      else if (ifu_arvalid && !ifu_rvalid)
      begin
        // one-cycle latency answers at once
        if (rng[1:0] == 2'd0)
        begin
          ifu_rvalid <= 1'b1;
          ifu_rdata  <= imem[ifu_araddr[9:2]];
        end
        else
        begin
          busy     <= 1'b1;
          req_addr <= ifu_araddr;
          wait_cnt <= {1'b0, rng[1:0]};
        end
        rng <= xorshift32(rng);
      end
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (!rst && commit_valid)
      commits <= commits + 1;
  end

  initial
  begin
    tb_errors = 0;
    load_program();
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    while (commits < END_COMMITS && cycles < MAX_CYCLES)
      @(posedge clk);
    if (commits < END_COMMITS)
    begin
      tb_errors++;
      $display("timeout: %0d of %0d commits after %0d cycles", commits, END_COMMITS, cycles);
    end
    $display("error count: assertions %0d, testbench %0d",
             u_core_top.u_props.fail_count, tb_errors);
    if (tb_errors == 0 && u_core_top.u_props.fail_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
hw/isa_pkg.sv
hw/core_pkg.sv
hw/fetch_icache.sv
hw/reg_file.sv
hw/decode.sv
hw/execute.sv
hw/result.sv
hw/core_top.sv
tests/core_properties.sv
tests/core_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module core_tb -f tb.f -o core_sim
./obj_dir/core_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
grep -qx "Finished with no errors" sim.log
